//--- logic/ddr_mmu_pkg.sv
package ddr_mmu_pkg;

    localparam int TDATA_W = 128;
    localparam int KEEP_W = TDATA_W / 8;
    localparam int ADDR_W = 32;
    localparam int LOCAL_ADDR_W = 28;
    localparam logic [ADDR_W-1:0] BASE_ADDR = 32'h0000_0000;
    localparam int BTT_W = 23;
    localparam int TAG_W = 4;
    localparam int ID_W = 8;
    // frame id lives at the top of the lower half-word
    localparam int ID_MSB = TDATA_W / 2 - 1;
    localparam logic [ID_W-1:0] HEADER_ID = 8'hAA;
    localparam logic [ID_W-1:0] FOOTER_ID = 8'h55;
    localparam int PAGE_BYTES = 4096;
    localparam int PAGE_W = $clog2(PAGE_BYTES);
    localparam int BEAT_BYTES = 16;
    localparam int FRAME_OVERHEAD = 32;
    localparam int DEFAULT_TRIGGER_LEN = 16;

    // fixed mover command fields, no realignment, one eof per command
    localparam logic CMD_DRR = 1'b0;
    localparam logic CMD_EOF = 1'b1;
    localparam logic [5:0] CMD_DSA = 6'd0;
    localparam logic CMD_BURST_INCR = 1'b1;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [BTT_W-1:0] btt_t;

    typedef struct packed {
        logic wrap;
        logic [LOCAL_ADDR_W-1:0] offset;
    } ring_ptr_t;

    typedef struct packed {
        logic [TDATA_W-1:0] data;
        logic last;
    } stream_beat_t;

    typedef struct packed {
        logic [3:0] reserved;
        tag_t tag;
        logic [ADDR_W-1:0] addr;
        logic drr;
        logic eof;
        logic [5:0] dsa;
        logic burst;
        btt_t btt;
    } datamover_cmd_t;

    typedef struct packed {
        logic eop;
        logic [BTT_W-1:0] brcvd;
        logic okay;
        logic slverr;
        logic decerr;
        logic interr;
        tag_t tag;
    } s2mm_sts_t;

    typedef struct packed {
        logic okay;
        logic slverr;
        logic decerr;
        logic interr;
        tag_t tag;
    } mm2s_sts_t;

    // next slot start, wrapping at the region top and never crossing a page
    function automatic ring_ptr_t ring_advance(ring_ptr_t ptr, btt_t btt);
        ring_ptr_t nxt;
        logic [LOCAL_ADDR_W:0] top;
        logic [BTT_W:0] page_fill;
        nxt = ptr;
        top = {1'b0, {LOCAL_ADDR_W{1'b1}}} - btt;
        page_fill = ptr.offset[PAGE_W-1:0] + {btt, 1'b0};
        if ({1'b0, ptr.offset} + btt > top) begin
            nxt.offset = '0;
            nxt.wrap = ~ptr.wrap;
        end else if (page_fill > PAGE_BYTES - 1) begin
            nxt.offset = {ptr.offset[LOCAL_ADDR_W-1:PAGE_W] + 1'b1, {PAGE_W{1'b0}}};
        end else begin
            nxt.offset = ptr.offset + btt;
        end
        return nxt;
    endfunction

endpackage

//--- logic/ddr_ring_mmu.sv
`timescale 1ns/1ps

module ddr_ring_mmu (
    input  logic ACLK,
    input  logic ARESET,
    input  logic SET_CONFIG,
    input  logic [15:0] MAX_TRIGGER_LENGTH,
    // frames from the generator
    input  ddr_mmu_pkg::stream_beat_t S_AXIS,
    input  logic S_AXIS_TVALID,
    output logic S_AXIS_TREADY,
    // mover write channel
    output ddr_mmu_pkg::datamover_cmd_t S2MM_CMD,
    output logic S2MM_CMD_TVALID,
    input  logic S2MM_CMD_TREADY,
    output ddr_mmu_pkg::stream_beat_t S2MM_DATA,
    output logic S2MM_DATA_TVALID,
    input  logic S2MM_DATA_TREADY,
    input  ddr_mmu_pkg::s2mm_sts_t S2MM_STS,
    input  logic S2MM_STS_TVALID,
    output logic S2MM_STS_TREADY,
    // mover read channel
    output ddr_mmu_pkg::datamover_cmd_t MM2S_CMD,
    output logic MM2S_CMD_TVALID,
    input  logic MM2S_CMD_TREADY,
    input  ddr_mmu_pkg::mm2s_sts_t MM2S_STS,
    input  logic MM2S_STS_TVALID,
    output logic MM2S_STS_TREADY,
    input  ddr_mmu_pkg::stream_beat_t MM2S_DATA,
    input  logic MM2S_DATA_TVALID,
    output logic MM2S_DATA_TREADY,
    // framed output
    output ddr_mmu_pkg::stream_beat_t M_AXIS,
    output logic [ddr_mmu_pkg::KEEP_W-1:0] M_AXIS_TKEEP,
    output logic M_AXIS_TVALID,
    input  logic M_AXIS_TREADY,
    output logic DATAMOVER_ERROR
);

    logic flush;
    logic s2mm_done;
    logic mm2s_done;
    logic s2mm_error;
    logic mm2s_error;
    logic s2mm_cmd_fire;
    logic room;
    logic empty;
    ddr_mmu_pkg::btt_t max_btt;
    ddr_mmu_pkg::ring_ptr_t write_slot;
    ddr_mmu_pkg::ring_ptr_t read_slot;

    // status words are always consumed
    assign S2MM_STS_TREADY = 1'b1;
    assign MM2S_STS_TREADY = 1'b1;
    assign DATAMOVER_ERROR = s2mm_error | mm2s_error;

    mover_status_decode #(
        .sts_t(ddr_mmu_pkg::s2mm_sts_t)
    ) u_s2mm_sts (
        .ACLK(ACLK),
        .ARESET(ARESET),
        .flush(flush),
        .sts_data(S2MM_STS),
        .sts_valid(S2MM_STS_TVALID),
        .done(s2mm_done),
        .error(s2mm_error)
    );

    mover_status_decode #(
        .sts_t(ddr_mmu_pkg::mm2s_sts_t)
    ) u_mm2s_sts (
        .ACLK(ACLK),
        .ARESET(ARESET),
        .flush(flush),
        .sts_data(MM2S_STS),
        .sts_valid(MM2S_STS_TVALID),
        .done(mm2s_done),
        .error(mm2s_error)
    );

    ring_address_ctrl u_ring (
        .ACLK(ACLK),
        .ARESET(ARESET),
        .set_config(SET_CONFIG),
        .max_trigger_length(MAX_TRIGGER_LENGTH),
        .s2mm_cmd_fire(s2mm_cmd_fire),
        .s2mm_done(s2mm_done),
        .mm2s_done(mm2s_done),
        .error(DATAMOVER_ERROR),
        .max_btt(max_btt),
        .write_slot(write_slot),
        .read_slot(read_slot),
        .room(room),
        .empty(empty),
        .flush(flush)
    );

    frame_writer u_writer (
        .ACLK(ACLK),
        .ARESET(ARESET),
        .flush(flush),
        .error(DATAMOVER_ERROR),
        .room(room),
        .max_btt(max_btt),
        .write_slot(write_slot),
        .s_beat(S_AXIS),
        .s_valid(S_AXIS_TVALID),
        .s_ready(S_AXIS_TREADY),
        .w_beat(S2MM_DATA),
        .w_valid(S2MM_DATA_TVALID),
        .w_ready(S2MM_DATA_TREADY),
        .cmd(S2MM_CMD),
        .cmd_valid(S2MM_CMD_TVALID),
        .cmd_ready(S2MM_CMD_TREADY),
        .s2mm_cmd_fire(s2mm_cmd_fire)
    );

    frame_reader u_reader (
        .ACLK(ACLK),
        .ARESET(ARESET),
        .flush(flush),
        .error(DATAMOVER_ERROR),
        .empty(empty),
        .mm2s_done(mm2s_done),
        .max_btt(max_btt),
        .read_slot(read_slot),
        .cmd(MM2S_CMD),
        .cmd_valid(MM2S_CMD_TVALID),
        .cmd_ready(MM2S_CMD_TREADY),
        .r_beat(MM2S_DATA),
        .r_valid(MM2S_DATA_TVALID),
        .r_ready(MM2S_DATA_TREADY),
        .m_beat(M_AXIS),
        .m_keep(M_AXIS_TKEEP),
        .m_valid(M_AXIS_TVALID),
        .m_ready(M_AXIS_TREADY)
    );

endmodule

//--- logic/frame_reader.sv
`timescale 1ns/1ps

module frame_reader (
    input  logic ACLK,
    input  logic ARESET,
    input  logic flush,
    input  logic error,
    input  logic empty,
    input  logic mm2s_done,
    input  ddr_mmu_pkg::btt_t max_btt,
    input  ddr_mmu_pkg::ring_ptr_t read_slot,
    output ddr_mmu_pkg::datamover_cmd_t cmd,
    output logic cmd_valid,
    input  logic cmd_ready,
    input  ddr_mmu_pkg::stream_beat_t r_beat,
    input  logic r_valid,
    output logic r_ready,
    output ddr_mmu_pkg::stream_beat_t m_beat,
    output logic [ddr_mmu_pkg::KEEP_W-1:0] m_keep,
    output logic m_valid,
    input  logic m_ready
);

    logic busy;
    logic cmd_fire;
    ddr_mmu_pkg::tag_t tag;
    logic [ddr_mmu_pkg::ID_W-1:0] r_id;
    logic is_header;
    logic is_footer;
    logic r_fire;
    logic out_end;
    // waiting: between mover bursts, a header may open a frame
    logic waiting;
    logic active;
    logic take;
    logic held;

    assign cmd_fire = cmd_valid & cmd_ready;

    // one read outstanding at a time
    always_ff @(posedge ACLK) begin
        if (ARESET || flush) begin
            busy <= 1'b0;
            cmd_valid <= 1'b0;
            tag <= '0;
        end else begin
            if (cmd_fire) begin
                busy <= 1'b1;
                cmd_valid <= 1'b0;
                tag <= tag + 1'b1;
            end else if (mm2s_done) begin
                busy <= 1'b0;
            end else if (!busy && !empty && !cmd_valid && !error) begin
                cmd_valid <= 1'b1;
            end
        end
    end

    always_comb begin
        cmd.reserved = '0;
        cmd.tag = tag;
        cmd.addr = ddr_mmu_pkg::ADDR_W'(read_slot.offset) + ddr_mmu_pkg::BASE_ADDR;
        cmd.drr = ddr_mmu_pkg::CMD_DRR;
        cmd.eof = ddr_mmu_pkg::CMD_EOF;
        cmd.dsa = ddr_mmu_pkg::CMD_DSA;
        cmd.burst = ddr_mmu_pkg::CMD_BURST_INCR;
        cmd.btt = max_btt;
    end

    assign r_id = r_beat.data[ddr_mmu_pkg::ID_MSB -: ddr_mmu_pkg::ID_W];
    assign is_header = (r_id == ddr_mmu_pkg::HEADER_ID);
    assign is_footer = (r_id == ddr_mmu_pkg::FOOTER_ID);

    assign r_ready = m_ready | ~held;
    assign r_fire = r_valid & r_ready;
    assign out_end = m_valid & m_ready & m_beat.last;
    // slot tail beats after the footer are dropped
    assign take = r_fire && ((is_header && waiting && !active) || (active && !out_end)
        || (is_header && waiting && out_end));

    always_ff @(posedge ACLK) begin
        if (ARESET || flush) begin
            waiting <= 1'b1;
        end else if (r_fire && r_beat.last) begin
            waiting <= 1'b1;
        end else if (r_fire && is_footer) begin
            waiting <= 1'b0;
        end
    end

    // a frame stays open until its footer has left the output register
    always_ff @(posedge ACLK) begin
        if (ARESET || flush) begin
            active <= 1'b0;
        end else if (r_fire && is_header && waiting && (!active || out_end)) begin
            active <= 1'b1;
        end else if (out_end) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET || flush) begin
            held <= 1'b0;
        end else if (r_ready) begin
            held <= take;
        end
    end

    // footer carries only the low half of the beat
    always_ff @(posedge ACLK) begin
        if (r_ready) begin
            m_beat.data <= r_beat.data;
            m_beat.last <= is_footer;
            if (is_footer) begin
                m_keep <= {{ddr_mmu_pkg::KEEP_W/2{1'b0}}, {ddr_mmu_pkg::KEEP_W/2{1'b1}}};
            end else begin
                m_keep <= '1;
            end
        end
    end

    assign m_valid = held;

endmodule

//--- logic/frame_writer.sv
`timescale 1ns/1ps

module frame_writer (
    input  logic ACLK,
    input  logic ARESET,
    input  logic flush,
    input  logic error,
    input  logic room,
    input  ddr_mmu_pkg::btt_t max_btt,
    input  ddr_mmu_pkg::ring_ptr_t write_slot,
    input  ddr_mmu_pkg::stream_beat_t s_beat,
    input  logic s_valid,
    output logic s_ready,
    output ddr_mmu_pkg::stream_beat_t w_beat,
    output logic w_valid,
    input  logic w_ready,
    output ddr_mmu_pkg::datamover_cmd_t cmd,
    output logic cmd_valid,
    input  logic cmd_ready,
    output logic s2mm_cmd_fire
);

    logic gate;
    logic beat_fire;
    logic header_fire;
    ddr_mmu_pkg::tag_t tag;

    // frames pass straight through while the gate is open
    assign w_beat = s_beat;
    assign w_valid = s_valid & gate;
    assign s_ready = w_ready & gate;

    assign beat_fire = s_valid & s_ready;
    assign header_fire = beat_fire && (s_beat.data[ddr_mmu_pkg::ID_MSB -: ddr_mmu_pkg::ID_W]
        == ddr_mmu_pkg::HEADER_ID);
    assign s2mm_cmd_fire = cmd_valid & cmd_ready;

    // closes behind every frame, reopens once the next slot is free
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            gate <= 1'b1;
        end else if (error) begin
            gate <= 1'b0;
        end else if (flush) begin
            gate <= 1'b1;
        end else if (beat_fire && s_beat.last) begin
            gate <= 1'b0;
        end else if (room && !cmd_valid) begin
            gate <= 1'b1;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET || flush) begin
            cmd_valid <= 1'b0;
            tag <= '0;
        end else begin
            if (header_fire) begin
                cmd_valid <= 1'b1;
            end else if (s2mm_cmd_fire) begin
                cmd_valid <= 1'b0;
            end
            if (s2mm_cmd_fire) begin
                tag <= tag + 1'b1;
            end
        end
    end

    always_comb begin
        cmd.reserved = '0;
        cmd.tag = tag;
        cmd.addr = ddr_mmu_pkg::ADDR_W'(write_slot.offset) + ddr_mmu_pkg::BASE_ADDR;
        cmd.drr = ddr_mmu_pkg::CMD_DRR;
        cmd.eof = ddr_mmu_pkg::CMD_EOF;
        cmd.dsa = ddr_mmu_pkg::CMD_DSA;
        cmd.burst = ddr_mmu_pkg::CMD_BURST_INCR;
        cmd.btt = max_btt;
    end

endmodule

//--- logic/mover_status_decode.sv
`timescale 1ns/1ps

module mover_status_decode #(
    parameter type sts_t = ddr_mmu_pkg::mm2s_sts_t
) (
    input  logic ACLK,
    input  logic ARESET,
    input  logic flush,
    input  sts_t sts_data,
    input  logic sts_valid,
    output logic done,
    output logic error
);

    ddr_mmu_pkg::tag_t exp_tag;
    logic hit;
    logic bad;

    // completion only counts when it answers the oldest command
    assign hit = sts_valid && sts_data.okay && (sts_data.tag == exp_tag);
    assign bad = sts_valid && (sts_data.slverr || sts_data.decerr || sts_data.interr);

    always_ff @(posedge ACLK) begin
        if (ARESET || flush) begin
            exp_tag <= '0;
            done <= 1'b0;
        end else begin
            done <= hit;
            if (hit) begin
                exp_tag <= exp_tag + 1'b1;
            end
        end
    end

    // sticky until reset
    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            error <= 1'b0;
        end else if (bad) begin
            error <= 1'b1;
        end
    end

endmodule

//--- logic/ring_address_ctrl.sv
`timescale 1ns/1ps

module ring_address_ctrl (
    input  logic ACLK,
    input  logic ARESET,
    input  logic set_config,
    input  logic [15:0] max_trigger_length,
    input  logic s2mm_cmd_fire,
    input  logic s2mm_done,
    input  logic mm2s_done,
    input  logic error,
    output ddr_mmu_pkg::btt_t max_btt,
    output ddr_mmu_pkg::ring_ptr_t write_slot,
    output ddr_mmu_pkg::ring_ptr_t read_slot,
    output logic room,
    output logic empty,
    output logic flush
);

    // cmd_ptr: next slot to command, wr_ptr: written, rd_ptr: next slot to read
    ddr_mmu_pkg::ring_ptr_t cmd_ptr;
    ddr_mmu_pkg::ring_ptr_t wr_ptr;
    ddr_mmu_pkg::ring_ptr_t rd_ptr;
    ddr_mmu_pkg::ring_ptr_t cmd_nxt;
    ddr_mmu_pkg::ring_ptr_t wr_nxt;
    ddr_mmu_pkg::ring_ptr_t rd_nxt;
    ddr_mmu_pkg::ring_ptr_t cmd_ahead;

    // same offset on opposite laps means the writer caught up with the reader
    function automatic logic collides(ddr_mmu_pkg::ring_ptr_t a, ddr_mmu_pkg::ring_ptr_t b);
        return (a.offset == b.offset) && (a.wrap != b.wrap);
    endfunction

    assign flush = set_config | error;
    assign write_slot = cmd_ptr;
    assign read_slot = rd_ptr;

    always_ff @(posedge ACLK) begin
        if (ARESET || error) begin
            max_btt <= ddr_mmu_pkg::btt_t'(ddr_mmu_pkg::DEFAULT_TRIGGER_LEN
                * ddr_mmu_pkg::BEAT_BYTES + ddr_mmu_pkg::FRAME_OVERHEAD);
        end else if (set_config) begin
            max_btt <= ddr_mmu_pkg::btt_t'(max_trigger_length
                * ddr_mmu_pkg::BEAT_BYTES + ddr_mmu_pkg::FRAME_OVERHEAD);
        end
    end

    always_comb begin
        cmd_nxt = cmd_ptr;
        wr_nxt = wr_ptr;
        rd_nxt = rd_ptr;
        if (flush) begin
            cmd_nxt = '0;
            wr_nxt = '0;
            rd_nxt = '0;
        end else begin
            if (s2mm_cmd_fire) begin
                cmd_nxt = ddr_mmu_pkg::ring_advance(cmd_ptr, max_btt);
            end
            if (s2mm_done) begin
                wr_nxt = ddr_mmu_pkg::ring_advance(wr_ptr, max_btt);
            end
            if (mm2s_done) begin
                rd_nxt = ddr_mmu_pkg::ring_advance(rd_ptr, max_btt);
            end
        end
    end

    // one slot of look-ahead for the write gate
    assign cmd_ahead = ddr_mmu_pkg::ring_advance(cmd_nxt, max_btt);

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            cmd_ptr <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            empty <= 1'b1;
            room <= 1'b1;
        end else begin
            cmd_ptr <= cmd_nxt;
            wr_ptr <= wr_nxt;
            rd_ptr <= rd_nxt;
            // flags track the pointers they are registered with
            empty <= (wr_nxt == rd_nxt);
            room <= !(collides(cmd_nxt, rd_nxt) || collides(cmd_ahead, rd_nxt));
        end
    end

endmodule

//--- sim/datamover_model.sv
`timescale 1ns/1ps

module datamover_model (
    input  logic ACLK,
    input  logic inject_slverr,
    input  ddr_mmu_pkg::datamover_cmd_t s2mm_cmd,
    input  logic s2mm_cmd_valid,
    output logic s2mm_cmd_ready,
    input  ddr_mmu_pkg::stream_beat_t s2mm_data,
    input  logic s2mm_data_valid,
    output logic s2mm_data_ready,
    output ddr_mmu_pkg::s2mm_sts_t s2mm_sts,
    output logic s2mm_sts_valid,
    input  ddr_mmu_pkg::datamover_cmd_t mm2s_cmd,
    input  logic mm2s_cmd_valid,
    output logic mm2s_cmd_ready,
    output ddr_mmu_pkg::mm2s_sts_t mm2s_sts,
    output logic mm2s_sts_valid,
    output ddr_mmu_pkg::stream_beat_t mm2s_data,
    output logic mm2s_data_valid,
    input  logic mm2s_data_ready
);

    // DDR by beat address, and the beat count of the frame stored at each slot
    logic [ddr_mmu_pkg::TDATA_W-1:0] mem [int unsigned];
    int unsigned frame_len [int unsigned];
    ddr_mmu_pkg::stream_beat_t wbeats [$];
    int frames_done;
    int seed;
    ddr_mmu_pkg::datamover_cmd_t wcmd;
    ddr_mmu_pkg::datamover_cmd_t rcmd;
    logic have_wcmd;
    logic have_rcmd;
    logic rd_fire;
    int unsigned rd_idx;

    function automatic logic [ddr_mmu_pkg::TDATA_W-1:0] read_beat(int unsigned slot,
                                                                 int unsigned idx);
        int unsigned a;
        a = slot / ddr_mmu_pkg::BEAT_BYTES + idx;
        if (frame_len.exists(slot) && idx < frame_len[slot] && mem.exists(a)) begin
            return mem[a];
        end
        // space behind the frame reads back a pattern of its own address
        return {4{~a}};
    endfunction

    initial begin
        seed = 72713;
        frames_done = 0;
        have_wcmd = 1'b0;
        have_rcmd = 1'b0;
        rd_fire = 1'b0;
        rd_idx = 0;
        s2mm_cmd_ready = 1'b0;
        s2mm_data_ready = 1'b0;
        s2mm_sts = '0;
        s2mm_sts_valid = 1'b0;
        mm2s_cmd_ready = 1'b0;
        mm2s_sts = '0;
        mm2s_sts_valid = 1'b0;
        mm2s_data = '0;
        mm2s_data_valid = 1'b0;
    end

    // write data, collected whole frames at a time
    always @(negedge ACLK) begin
        s2mm_data_ready = ($random(seed) & 3) != 0;
        #1;
        if (s2mm_data_valid && s2mm_data_ready) begin
            wbeats.push_back(s2mm_data);
            if (s2mm_data.last) begin
                frames_done++;
            end
        end
    end

    // write command, stored once its frame is complete, then a status beat
    always @(negedge ACLK) begin
        int unsigned n;
        ddr_mmu_pkg::stream_beat_t b;
        s2mm_sts_valid = 1'b0;
        if (have_wcmd && frames_done > 0) begin
            n = 0;
            do begin
                b = wbeats.pop_front();
                mem[wcmd.addr / ddr_mmu_pkg::BEAT_BYTES + n] = b.data;
                n++;
            end while (!b.last);
            frames_done--;
            frame_len[wcmd.addr] = n;
            s2mm_sts = '0;
            s2mm_sts.eop = 1'b1;
            s2mm_sts.brcvd = ddr_mmu_pkg::BTT_W'(n * ddr_mmu_pkg::BEAT_BYTES);
            s2mm_sts.okay = !inject_slverr;
            s2mm_sts.slverr = inject_slverr;
            s2mm_sts.tag = wcmd.tag;
            s2mm_sts_valid = 1'b1;
            have_wcmd = 1'b0;
        end
        s2mm_cmd_ready = !have_wcmd && ($random(seed) & 1);
        #1;
        if (s2mm_cmd_valid && s2mm_cmd_ready) begin
            wcmd = s2mm_cmd;
            have_wcmd = 1'b1;
        end
    end

    // read channel returns the whole slot, last on its final beat
    always @(negedge ACLK) begin
        mm2s_sts_valid = 1'b0;
        if (rd_fire) begin
            rd_idx++;
            if (rd_idx == rcmd.btt / ddr_mmu_pkg::BEAT_BYTES) begin
                mm2s_data_valid = 1'b0;
                mm2s_sts = '0;
                mm2s_sts.okay = 1'b1;
                mm2s_sts.tag = rcmd.tag;
                mm2s_sts_valid = 1'b1;
                have_rcmd = 1'b0;
            end
        end
        if (have_rcmd) begin
            mm2s_data.data = read_beat(rcmd.addr, rd_idx);
            mm2s_data.last = (rd_idx == rcmd.btt / ddr_mmu_pkg::BEAT_BYTES - 1);
            mm2s_data_valid = 1'b1;
        end
        mm2s_cmd_ready = !have_rcmd && ($random(seed) & 1);
        #1;
        if (mm2s_cmd_valid && mm2s_cmd_ready) begin
            rcmd = mm2s_cmd;
            have_rcmd = 1'b1;
            rd_idx = 0;
        end
        rd_fire = mm2s_data_valid && mm2s_data_ready;
    end

endmodule

//--- sim/tb_ddr_ring_mmu.sv
`timescale 1ns/1ps

module tb_ddr_ring_mmu;

    localparam int BEAT_TIMEOUT = 5000;
    localparam int DRAIN_TIMEOUT = 100000;

    logic ACLK;
    logic ARESET;
    logic SET_CONFIG;
    logic [15:0] MAX_TRIGGER_LENGTH;
    ddr_mmu_pkg::stream_beat_t S_AXIS;
    logic S_AXIS_TVALID;
    logic S_AXIS_TREADY;
    ddr_mmu_pkg::datamover_cmd_t S2MM_CMD;
    logic S2MM_CMD_TVALID;
    logic S2MM_CMD_TREADY;
    ddr_mmu_pkg::stream_beat_t S2MM_DATA;
    logic S2MM_DATA_TVALID;
    logic S2MM_DATA_TREADY;
    ddr_mmu_pkg::s2mm_sts_t S2MM_STS;
    logic S2MM_STS_TVALID;
    logic S2MM_STS_TREADY;
    ddr_mmu_pkg::datamover_cmd_t MM2S_CMD;
    logic MM2S_CMD_TVALID;
    logic MM2S_CMD_TREADY;
    ddr_mmu_pkg::mm2s_sts_t MM2S_STS;
    logic MM2S_STS_TVALID;
    logic MM2S_STS_TREADY;
    ddr_mmu_pkg::stream_beat_t MM2S_DATA;
    logic MM2S_DATA_TVALID;
    logic MM2S_DATA_TREADY;
    ddr_mmu_pkg::stream_beat_t M_AXIS;
    logic [ddr_mmu_pkg::KEEP_W-1:0] M_AXIS_TKEEP;
    logic M_AXIS_TVALID;
    logic M_AXIS_TREADY;
    logic DATAMOVER_ERROR;

    logic inject_slverr;
    logic expect_error;
    logic page_check;
    int seed;
    int frames_sent;
    int rd_sts_count;
    int unsigned btt_exp;
    int unsigned wr_off;
    int unsigned rd_off;
    int unsigned wr_tag;
    int unsigned rd_tag;
    ddr_mmu_pkg::stream_beat_t exp_beats [$];

    ddr_ring_mmu uut (.*);

    datamover_model u_mover (
        .ACLK(ACLK),
        .inject_slverr(inject_slverr),
        .s2mm_cmd(S2MM_CMD),
        .s2mm_cmd_valid(S2MM_CMD_TVALID),
        .s2mm_cmd_ready(S2MM_CMD_TREADY),
        .s2mm_data(S2MM_DATA),
        .s2mm_data_valid(S2MM_DATA_TVALID),
        .s2mm_data_ready(S2MM_DATA_TREADY),
        .s2mm_sts(S2MM_STS),
        .s2mm_sts_valid(S2MM_STS_TVALID),
        .mm2s_cmd(MM2S_CMD),
        .mm2s_cmd_valid(MM2S_CMD_TVALID),
        .mm2s_cmd_ready(MM2S_CMD_TREADY),
        .mm2s_sts(MM2S_STS),
        .mm2s_sts_valid(MM2S_STS_TVALID),
        .mm2s_data(MM2S_DATA),
        .mm2s_data_valid(MM2S_DATA_TVALID),
        .mm2s_data_ready(MM2S_DATA_TREADY)
    );

    initial ACLK = 1'b0;
    always #10 ACLK = ~ACLK;

    // slot size for a trigger length
    function automatic int unsigned slot_bytes(int unsigned trig);
        return trig * 16 + 32;
    endfunction

    // next slot start wrapping at the region top and never straddling a 4 KiB page
    function automatic int unsigned next_slot(int unsigned off, int unsigned btt);
        longint unsigned top;
        top = (longint'(1) << ddr_mmu_pkg::LOCAL_ADDR_W) - 1;
        if (longint'(off) + btt > top - btt) begin
            return 0;
        end
        if ((off % 4096) + 2 * btt > 4095) begin
            return (off / 4096 + 1) * 4096;
        end
        return off + btt;
    endfunction

    function automatic logic [ddr_mmu_pkg::KEEP_W-1:0] keep_for(logic footer);
        return footer ? 16'h00FF : 16'hFFFF;
    endfunction

    task automatic fail_now(input string msg);
        $display("Checks failed");
        $display("%s", msg);
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] exp,
                               input logic [127:0] act);
        assert (exp === act) else
            fail_now($sformatf("Fail at %0t ns: %s expected %h, got %h",
                $time, name, exp, act));
    endtask

    // one command beat against its expected slot, tag and fixed fields
    task automatic check_cmd(input string ch, input ddr_mmu_pkg::datamover_cmd_t c,
                             input int unsigned addr, input int unsigned tag);
        check_value({ch, ".addr"}, addr, c.addr);
        check_value({ch, ".btt"}, btt_exp, c.btt);
        check_value({ch, ".tag"}, tag % 16, c.tag);
        check_value({ch, ".reserved"}, 0, c.reserved);
        check_value({ch, ".drr"}, 0, c.drr);
        check_value({ch, ".eof"}, 1, c.eof);
        check_value({ch, ".dsa"}, 0, c.dsa);
        check_value({ch, ".burst"}, 1, c.burst);
        assert (!page_check || c.addr[11:0] == 0) else
            fail_now({ch, " address is not on a page start"});
    endtask

    task automatic drive_beat(input ddr_mmu_pkg::stream_beat_t b);
        int n;
        logic sent;
        n = 0;
        sent = 1'b0;
        // an idle cycle now and then
        if (($random(seed) & 3) == 0) begin
            @(negedge ACLK);
            S_AXIS_TVALID = 1'b0;
        end
        while (!sent) begin
            @(negedge ACLK);
            S_AXIS = b;
            S_AXIS_TVALID = 1'b1;
            #1;
            sent = S_AXIS_TREADY;
            n++;
            if (!sent && n > BEAT_TIMEOUT) begin
                fail_now("timeout: S_AXIS_TREADY never came for a frame beat");
            end
        end
    endtask

    // header, random payload and a footer with last
    task automatic send_frame(input int unsigned payload, input logic readback);
        ddr_mmu_pkg::stream_beat_t b;
        logic [7:0] id;
        for (int i = 0; i < payload + 2; i++) begin
            b.data = {$random(seed), $random(seed), $random(seed), $random(seed)};
            b.last = (i == payload + 1);
            id = b.data[63:56];
            if (i == 0) begin
                id = 8'hAA;
            end else if (b.last) begin
                id = 8'h55;
            end else if (id == 8'hAA || id == 8'h55) begin
                id = id ^ 8'h01;
            end
            b.data[63:56] = id;
            if (readback) begin
                exp_beats.push_back(b);
            end
            drive_beat(b);
        end
        frames_sent++;
        @(negedge ACLK);
        S_AXIS_TVALID = 1'b0;
    endtask

    task automatic wait_readback(input int frames);
        int cycles;
        cycles = 0;
        while (rd_sts_count < frames || exp_beats.size() != 0) begin
            @(negedge ACLK);
            #2;
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                fail_now("timeout: frames did not all come back on M_AXIS");
            end
        end
    endtask

    // compares once the falling edge drives have settled
    always @(negedge ACLK) begin
        ddr_mmu_pkg::stream_beat_t e;
        M_AXIS_TREADY = ($random(seed) & 3) != 0;
        #1;
        if (!ARESET) begin
            if (M_AXIS_TVALID && M_AXIS_TREADY) begin
                assert (exp_beats.size() > 0) else
                    fail_now("M_AXIS delivered a beat that was never sent");
                e = exp_beats.pop_front();
                check_value("M_AXIS.data", e.data, M_AXIS.data);
                check_value("M_AXIS.last", e.last, M_AXIS.last);
                check_value("M_AXIS_TKEEP", keep_for(e.last), M_AXIS_TKEEP);
            end
            if (S2MM_CMD_TVALID && S2MM_CMD_TREADY) begin
                check_cmd("S2MM_CMD", S2MM_CMD, wr_off, wr_tag);
                wr_off = next_slot(wr_off, btt_exp);
                wr_tag++;
            end
            if (MM2S_CMD_TVALID && MM2S_CMD_TREADY) begin
                check_cmd("MM2S_CMD", MM2S_CMD, rd_off, rd_tag);
                rd_off = next_slot(rd_off, btt_exp);
                rd_tag++;
            end
            if (S2MM_STS_TVALID) begin
                check_value("S2MM_STS_TREADY", 1, S2MM_STS_TREADY);
            end
            if (MM2S_STS_TVALID) begin
                check_value("MM2S_STS_TREADY", 1, MM2S_STS_TREADY);
                rd_sts_count++;
            end
            if (!expect_error) begin
                check_value("DATAMOVER_ERROR", 0, DATAMOVER_ERROR);
            end
        end
    end

    initial begin
        int cycles;
        seed = 72713;
        ARESET = 1'b1;
        SET_CONFIG = 1'b0;
        MAX_TRIGGER_LENGTH = ddr_mmu_pkg::DEFAULT_TRIGGER_LEN;
        S_AXIS = '0;
        S_AXIS_TVALID = 1'b0;
        M_AXIS_TREADY = 1'b0;
        inject_slverr = 1'b0;
        expect_error = 1'b0;
        page_check = 1'b0;
        frames_sent = 0;
        rd_sts_count = 0;
        btt_exp = slot_bytes(ddr_mmu_pkg::DEFAULT_TRIGGER_LEN);
        wr_off = 0;
        rd_off = 0;
        wr_tag = 0;
        rd_tag = 0;
        repeat (3) @(negedge ACLK);
        ARESET = 1'b0;
        #1;
        check_value("S2MM_CMD_TVALID", 0, S2MM_CMD_TVALID);
        check_value("MM2S_CMD_TVALID", 0, MM2S_CMD_TVALID);
        check_value("M_AXIS_TVALID", 0, M_AXIS_TVALID);
        check_value("S_AXIS_TREADY", S2MM_DATA_TREADY, S_AXIS_TREADY);

        // default slot size with enough frames to cross a page
        for (int k = 0; k < 24; k++) begin
            send_frame(1 + $unsigned($random(seed)) % 16, 1'b1);
        end
        wait_readback(frames_sent);

        // new trigger length so that two slots no longer fit in a page
        @(negedge ACLK);
        SET_CONFIG = 1'b1;
        MAX_TRIGGER_LENGTH = 16'd200;
        btt_exp = slot_bytes(200);
        wr_off = 0;
        rd_off = 0;
        wr_tag = 0;
        rd_tag = 0;
        page_check = 1'b1;
        @(negedge ACLK);
        SET_CONFIG = 1'b0;
        for (int k = 0; k < 6; k++) begin
            send_frame(1 + $unsigned($random(seed)) % 200, 1'b1);
        end
        wait_readback(frames_sent);

        // slverr on the next write status
        inject_slverr = 1'b1;
        expect_error = 1'b1;
        send_frame(4, 1'b0);
        cycles = 0;
        while (DATAMOVER_ERROR !== 1'b1) begin
            @(negedge ACLK);
            #1;
            cycles++;
            if (cycles > BEAT_TIMEOUT) begin
                fail_now("timeout: DATAMOVER_ERROR never rose after slverr");
            end
        end
        repeat (20) begin
            @(negedge ACLK);
            S_AXIS.data = '0;
            S_AXIS.data[63:56] = 8'hAA;
            S_AXIS.last = 1'b0;
            S_AXIS_TVALID = 1'b1;
            #1;
            check_value("DATAMOVER_ERROR", 1, DATAMOVER_ERROR);
            check_value("S_AXIS_TREADY", 0, S_AXIS_TREADY);
            check_value("S2MM_CMD_TVALID", 0, S2MM_CMD_TVALID);
            check_value("MM2S_CMD_TVALID", 0, MM2S_CMD_TVALID);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

//--- sources.f
logic/ddr_mmu_pkg.sv
logic/mover_status_decode.sv
logic/ring_address_ctrl.sv
logic/frame_writer.sv
logic/frame_reader.sv
logic/ddr_ring_mmu.sv
sim/datamover_model.sv
sim/tb_ddr_ring_mmu.sv
